//--- ahbl_subsys_tests.txt
# id m0:issue write addr wdata  m1:issue write addr wdata  m0:exp_rdata exp_err  m1:exp_rdata exp_err
# id is decimal, all other columns hex, rdata is 0 for writes and errors
1  1 1 00000000 11112222  0 0 00000000 00000000  00000000 0  00000000 0
2  1 0 00000000 00000000  0 0 00000000 00000000  11112222 0  00000000 0
3  0 0 00000000 00000000  1 1 00000020 a5a5a5a5  00000000 0  00000000 0
4  0 0 00000000 00000000  1 0 00000020 00000000  00000000 0  a5a5a5a5 0
5  1 1 00000030 deadbeef  1 1 00000034 12345678  00000000 0  00000000 0
6  1 0 00000034 00000000  1 0 00000030 00000000  12345678 0  deadbeef 0
7  1 1 00000040 cafef00d  0 0 00000000 00000000  00000000 0  00000000 0
8  0 0 00000000 00000000  1 0 00000040 00000000  00000000 0  cafef00d 0
9  1 1 00000100 badbad00  0 0 00000000 00000000  00000000 1  00000000 0
10 0 0 00000000 00000000  1 0 00000000 00000000  00000000 0  11112222 0
11 1 0 00000104 00000000  1 1 00000200 0f0f0f0f  00000000 1  00000000 1
12 1 1 00000050 0badf00d  1 0 00000000 00000000  00000000 0  11112222 0
13 1 0 00000050 00000000  1 1 00000054 5555aaaa  0badf00d 0  00000000 0
14 1 0 00000054 00000000  1 0 00000050 00000000  5555aaaa 0  0badf00d 0
15 1 1 00000020 01020304  1 0 00000020 00000000  00000000 0  01020304 0
16 1 1 000000f8 0000ffff  1 1 000000fc ffff0000  00000000 0  00000000 0
17 1 0 000000fc 00000000  1 0 000000f8 00000000  ffff0000 0  0000ffff 0
18 0 0 00000000 00000000  1 0 000003fc 00000000  00000000 0  00000000 1
19 1 0 00000000 00000000  1 0 00000040 00000000  11112222 0  cafef00d 0
20 1 0 00000030 00000000  1 0 00000034 00000000  deadbeef 0  12345678 0

//--- ahbl_subsys.f
ahbl_pkg.sv
ahbl_cmd_master.sv
ahbl_arbiter.sv
ahbl_sram.sv
ahbl_subsys.sv
ahbl_subsys_asserts.sv
tb_ahbl_subsys.sv

//--- Makefile
VERILATOR  = verilator
SIM_FLAGS  = --binary --timing --assert -Wno-fatal
LINT_FLAGS = --lint-only --timing --assert -Wall
TOP        = tb_ahbl_subsys
FILELIST   = ahbl_subsys.f
LOG        = sim.log
FAIL_MSG   = Some tests failed
PASS_MSG   = All tests passed

.PHONY: lint sim clean

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

sim:
	$(VERILATOR) $(SIM_FLAGS) --top-module $(TOP) -f $(FILELIST)
	-./obj_dir/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then echo "Simulation reported failure"; exit 1; fi
	@grep -q "$(PASS_MSG)" $(LOG) || { echo "Simulation ended early"; exit 1; }

clean:
	rm -rf obj_dir $(LOG)

//--- tb_ahbl_subsys.sv
`timescale 1ns/1ps
`default_nettype none

module tb_ahbl_subsys;

	localparam int N_PORTS     = 2;
	localparam int DEPTH       = 64;
	localparam int WAIT_STATES = 1;

	// One command and its expected result as read from the tests file
	typedef struct packed {
		logic             issue;
		logic             write;
		ahbl_pkg::haddr_t addr;
		ahbl_pkg::hdata_t wdata;
		ahbl_pkg::hdata_t exp_rdata;
		logic             exp_err;
	} cmd_t;

	logic clk;
	logic rst_n;

	// Index 0 is master 0 and index 1 is master 1
	logic [1:0]                  cmd_valid;
	logic [1:0]                  cmd_write;
	ahbl_pkg::haddr_t [1:0]      cmd_addr;
	ahbl_pkg::hdata_t [1:0]      cmd_wdata;
	logic [1:0]                  busy;
	logic [1:0]                  done;
	ahbl_pkg::hdata_t [1:0]      rdata;
	logic [1:0]                  err;

	// Two entries per test with master 0 first
	cmd_t cmd_q [$];
	int   id_q [$];
	int   n_tests = 0;

	// Reference memory
	ahbl_pkg::hdata_t mem_model [DEPTH];
	logic             mem_set [DEPTH];

	int     errors = 0;
	int     checks = 0;
	logic   test_ok;
	integer seed = 32'ha881df5a;

	ahbl_subsys #(
		.N_PORTS     (N_PORTS),
		.DEPTH       (DEPTH),
		.WAIT_STATES (WAIT_STATES)
	) i_dut (
		.clk          (clk),
		.rst_n        (rst_n),
		.m0_cmd_valid (cmd_valid[0]),
		.m0_cmd_write (cmd_write[0]),
		.m0_cmd_addr  (cmd_addr[0]),
		.m0_cmd_wdata (cmd_wdata[0]),
		.m0_busy      (busy[0]),
		.m0_done      (done[0]),
		.m0_rdata     (rdata[0]),
		.m0_err       (err[0]),
		.m1_cmd_valid (cmd_valid[1]),
		.m1_cmd_write (cmd_write[1]),
		.m1_cmd_addr  (cmd_addr[1]),
		.m1_cmd_wdata (cmd_wdata[1]),
		.m1_busy      (busy[1]),
		.m1_done      (done[1]),
		.m1_rdata     (rdata[1]),
		.m1_err       (err[1])
	);

	// Protocol checker on the shared bus
	bind ahbl_arbiter ahbl_subsys_asserts #(.N_PORTS(N_PORTS)) i_asserts (
		.clk        (clk),
		.rst_n      (rst_n),
		.dst_req    (dst_req),
		.dst_hready (dst_hready),
		.dst_resp   (dst_resp),
		.gnt_d      (gnt_d)
	);

	initial begin
		clk = 1'b0;
		forever #50 clk = ~clk;
	end

	task automatic count_failure();
		errors++;
		test_ok = 1'b0;
	endtask

	task automatic load_tests();
		int          fd;
		int          n;
		string       line;
		logic [31:0] f [13];
		cmd_t        c;
		fd = $fopen("ahbl_subsys_tests.txt", "r");
		if (fd == 0) begin
			$display("Cannot open ahbl_subsys_tests.txt");
			errors++;
		end else begin
			while (!$feof(fd)) begin
				line = "";
				n = $fgets(line, fd);
				// Skip comments and blank lines
				if (line.len() > 0 && line[0] != "#") begin
					n = $sscanf(line, "%d %h %h %h %h %h %h %h %h %h %h %h %h",
						f[0], f[1], f[2], f[3], f[4], f[5], f[6],
						f[7], f[8], f[9], f[10], f[11], f[12]);
					if (n == 13) begin
						id_q.push_back(int'(f[0]));
						c = '{f[1][0], f[2][0], f[3], f[4], f[9], f[10][0]};
						cmd_q.push_back(c);
						c = '{f[5][0], f[6][0], f[7], f[8], f[11], f[12][0]};
						cmd_q.push_back(c);
					end
				end
			end
			$fclose(fd);
			n_tests = id_q.size();
			if (n_tests == 0) begin
				$display("No tests found in ahbl_subsys_tests.txt");
				errors++;
			end
		end
	endtask

	// Compare one completed command with the model and then update it
	task automatic check_result(input int id, input int m, input cmd_t c,
			input ahbl_pkg::hdata_t got_rdata, input logic got_err);
		logic             exp_err;
		int               idx;
		ahbl_pkg::hdata_t exp_rdata;
		exp_err = (c.addr[ahbl_pkg::W_ADDR-1:2] >= DEPTH);
		idx = exp_err ? 0 : int'(c.addr[ahbl_pkg::W_ADDR-1:2]);
		checks++;
		assert (c.exp_err == exp_err) else begin
			$display("Test %0d master %0d: the file's error flag disagrees with the model", id, m);
			count_failure();
		end
		assert (got_err == exp_err) else begin
			$display("ERROR at %0t: test %0d master %0d err %0b, expected %0b",
				$time, id, m, got_err, exp_err);
			count_failure();
		end
		if (!exp_err && !c.write) begin
			exp_rdata = mem_model[idx];
			assert (mem_set[idx]) else begin
				$display("Test %0d master %0d reads a word that was never written", id, m);
				count_failure();
			end
			assert (c.exp_rdata == exp_rdata) else begin
				$display("Test %0d master %0d: the file's read data disagrees with the model",
					id, m);
				count_failure();
			end
			assert (got_rdata === exp_rdata) else begin
				$display("ERROR at %0t: test %0d master %0d rdata %h, expected %h",
					$time, id, m, got_rdata, exp_rdata);
				count_failure();
			end
		end
		// Failed writes leave memory alone
		if (!exp_err && c.write) begin
			mem_model[idx] = c.wdata;
			mem_set[idx]   = 1'b1;
		end
	endtask

	task automatic run_test(input int t);
		cmd_t             c [2];
		logic [1:0]       want;
		logic [1:0]       seen;
		int               done_cyc [2];
		ahbl_pkg::hdata_t got_rdata [2];
		logic             got_err [2];
		int               cyc;
		c[0] = cmd_q[2*t];
		c[1] = cmd_q[2*t+1];
		want = {c[1].issue, c[0].issue};
		seen = '0;
		cyc = 0;
		test_ok = 1'b1;
		@(negedge clk);
		for (int m = 0; m < 2; m++) begin
			cmd_valid[m] = c[m].issue;
			cmd_write[m] = c[m].write;
			cmd_addr[m]  = c[m].addr;
			cmd_wdata[m] = c[m].wdata;
		end
		// Wait for one done per issued command
		while ((seen & want) != want) begin
			@(negedge clk);
			cmd_valid = '0;
			cyc++;
			for (int m = 0; m < 2; m++) begin
				// Busy rises on the cycle after the command
				if (cyc == 1 && want[m]) begin
					assert (busy[m]) else begin
						$display("ERROR at %0t: test %0d master %0d not busy after its command",
							$time, id_q[t], m);
						count_failure();
					end
				end
				if (done[m]) begin
					assert (want[m] && !seen[m]) else begin
						$display("Master %0d gave an unexpected done in test %0d", m, id_q[t]);
						count_failure();
					end
					assert (!busy[m]) else begin
						$display("Master %0d still busy at done in test %0d", m, id_q[t]);
						count_failure();
					end
					seen[m]      = 1'b1;
					done_cyc[m]  = cyc;
					got_rdata[m] = rdata[m];
					got_err[m]   = err[m];
				end
			end
		end
		// Master 0 wins so its result goes into the model first
		for (int m = 0; m < 2; m++) begin
			if (want[m])
				check_result(id_q[t], m, c[m], got_rdata[m], got_err[m]);
		end
		if (want == 2'b11) begin
			assert (done_cyc[0] <= done_cyc[1]) else begin
				$display("ERROR at %0t: test %0d master 0 done at cycle %0d, after master 1 at %0d",
					$time, id_q[t], done_cyc[0], done_cyc[1]);
				count_failure();
			end
		end
		$display("Test %0d: %s", id_q[t], test_ok ? "ok" : "mismatch");
	endtask

	initial begin
		int gap;
		rst_n     = 1'b0;
		cmd_valid = '0;
		cmd_write = '0;
		cmd_addr  = '0;
		cmd_wdata = '0;
		for (int i = 0; i < DEPTH; i++)
			mem_set[i] = 1'b0;
		load_tests();
		repeat (4) @(negedge clk);
		rst_n = 1'b1;
		for (int t = 0; t < n_tests; t++) begin
			// Idle gap of 0 to 3 cycles
			gap = $unsigned($random(seed)) % 4;
			repeat (gap) @(negedge clk);
			run_test(t);
		end
		repeat (2) @(negedge clk);
		$display("%0d tests, %0d checks, %0d errors", n_tests, checks, errors);
		if (errors == 0) begin
			$display("All tests passed");
		end else begin
			$display("Some tests failed");
		end
		$finish;
	end

	// Budget of 40 cycles per test plus reset and gaps
	initial begin
		wait (n_tests > 0);
		repeat (n_tests * 40 + 100) @(posedge clk);
		$display("Timeout: the tests did not finish in the expected number of cycles");
		$display("Some tests failed");
		$finish;
	end

endmodule

`default_nettype wire

//--- ahbl_subsys_asserts.sv
`timescale 1ns/1ps
`default_nettype none

module ahbl_subsys_asserts #(
	parameter int N_PORTS = 2
) (
	input logic                 clk,
	input logic                 rst_n,
	input ahbl_pkg::ahbl_req_t  dst_req,
	input logic                 dst_hready,
	input ahbl_pkg::ahbl_resp_t dst_resp,
	input logic [N_PORTS-1:0]   gnt_d
);

	// Only single transfers reach the slave
	htrans_legal: assert property (@(posedge clk) disable iff (!rst_n)
		dst_req.htrans == ahbl_pkg::IDLE || dst_req.htrans == ahbl_pkg::NONSEQ)
		else $error("slave side htrans is neither IDLE nor NONSEQ");

	// Pending address phase held through wait states
	req_stable: assert property (@(posedge clk) disable iff (!rst_n)
		!dst_hready && dst_req.htrans == ahbl_pkg::NONSEQ |=> $stable(dst_req))
		else $error("slave side request changed while hready was low");

	// Data phase owned by one port at most
	gnt_onehot: assert property (@(posedge clk) disable iff (!rst_n)
		$onehot0(gnt_d))
		else $error("more than one data phase grant held");

	// Any ERROR cycle not preceded by a first ERROR cycle must be the first one
	err_two_cycle: assert property (@(posedge clk) disable iff (!rst_n)
		dst_resp.hresp && !$past(dst_resp.hresp && !dst_resp.hready_resp)
		|-> !dst_resp.hready_resp)
		else $error("ERROR response started with hready high");

endmodule

`default_nettype wire

//--- ahbl_subsys.sv
`timescale 1ns/1ps
`default_nettype none

module ahbl_subsys #(
	parameter int N_PORTS     = 2,
	parameter int DEPTH       = 64,
	parameter int WAIT_STATES = 1
) (
	input  logic             clk,
	input  logic             rst_n,

	// Master 0 command port
	input  logic             m0_cmd_valid,
	input  logic             m0_cmd_write,
	input  ahbl_pkg::haddr_t m0_cmd_addr,
	input  ahbl_pkg::hdata_t m0_cmd_wdata,
	output logic             m0_busy,
	output logic             m0_done,
	output ahbl_pkg::hdata_t m0_rdata,
	output logic             m0_err,

	// Master 1 command port
	input  logic             m1_cmd_valid,
	input  logic             m1_cmd_write,
	input  ahbl_pkg::haddr_t m1_cmd_addr,
	input  ahbl_pkg::hdata_t m1_cmd_wdata,
	output logic             m1_busy,
	output logic             m1_done,
	output ahbl_pkg::hdata_t m1_rdata,
	output logic             m1_err
);

	// Master to arbiter
	ahbl_pkg::ahbl_req_t  [N_PORTS-1:0] src_req;
	ahbl_pkg::hdata_t     [N_PORTS-1:0] src_hwdata;
	ahbl_pkg::ahbl_resp_t [N_PORTS-1:0] src_resp;

	// Arbiter to SRAM
	ahbl_pkg::ahbl_req_t  dst_req;
	ahbl_pkg::hdata_t     dst_hwdata;
	logic                 dst_hready;
	ahbl_pkg::ahbl_resp_t dst_resp;

	// Port 0 wins arbitration
	ahbl_cmd_master i_master0 (
		.clk       (clk),
		.rst_n     (rst_n),
		.cmd_valid (m0_cmd_valid),
		.cmd_write (m0_cmd_write),
		.cmd_addr  (m0_cmd_addr),
		.cmd_wdata (m0_cmd_wdata),
		.busy      (m0_busy),
		.done      (m0_done),
		.rdata     (m0_rdata),
		.err       (m0_err),
		.req       (src_req[0]),
		.hwdata    (src_hwdata[0]),
		.resp      (src_resp[0])
	);

	ahbl_cmd_master i_master1 (
		.clk       (clk),
		.rst_n     (rst_n),
		.cmd_valid (m1_cmd_valid),
		.cmd_write (m1_cmd_write),
		.cmd_addr  (m1_cmd_addr),
		.cmd_wdata (m1_cmd_wdata),
		.busy      (m1_busy),
		.done      (m1_done),
		.rdata     (m1_rdata),
		.err       (m1_err),
		.req       (src_req[1]),
		.hwdata    (src_hwdata[1]),
		.resp      (src_resp[1])
	);

	ahbl_arbiter #(
		.N_PORTS (N_PORTS)
	) i_arbiter (
		.clk        (clk),
		.rst_n      (rst_n),
		.src_req    (src_req),
		.src_hwdata (src_hwdata),
		.src_resp   (src_resp),
		.dst_req    (dst_req),
		.dst_hwdata (dst_hwdata),
		.dst_hready (dst_hready),
		.dst_resp   (dst_resp)
	);

	ahbl_sram #(
		.DEPTH       (DEPTH),
		.WAIT_STATES (WAIT_STATES)
	) i_sram (
		.clk    (clk),
		.rst_n  (rst_n),
		.req    (dst_req),
		.hwdata (dst_hwdata),
		.hready (dst_hready),
		.resp   (dst_resp)
	);

endmodule

`default_nettype wire

//--- ahbl_sram.sv
`timescale 1ns/1ps
`default_nettype none

module ahbl_sram #(
	parameter int DEPTH       = 64,
	parameter int WAIT_STATES = 1
) (
	input  logic                 clk,
	input  logic                 rst_n,
	input  ahbl_pkg::ahbl_req_t  req,
	input  ahbl_pkg::hdata_t     hwdata,
	input  logic                 hready,
	output ahbl_pkg::ahbl_resp_t resp
);

	localparam int IDX_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
	localparam int CNT_W = (WAIT_STATES > 1) ? $clog2(WAIT_STATES) : 1;

	ahbl_pkg::hdata_t mem [DEPTH];

	// Data phase state
	logic             active;
	logic             write_q;
	logic [IDX_W-1:0] word_q;
	logic [CNT_W-1:0] wait_cnt;
	logic             hready_q;
	logic             hresp_q;

	logic accept;
	logic out_of_range;

	assign accept = hready && req.htrans == ahbl_pkg::NONSEQ;
	// Word index past the array end
	assign out_of_range = req.haddr[ahbl_pkg::W_ADDR-1:2] >= DEPTH;

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			active   <= 1'b0;
			hready_q <= 1'b1;
			hresp_q  <= 1'b0;
			wait_cnt <= '0;
		end else if (hready) begin
			// Previous data phase done, new address phase may start
			active <= accept;
			if (accept && out_of_range) begin
				hresp_q  <= 1'b1;
				hready_q <= 1'b0;
			end else if (accept) begin
				hresp_q  <= 1'b0;
				hready_q <= (WAIT_STATES == 0);
				wait_cnt <= (WAIT_STATES > 0) ? CNT_W'(WAIT_STATES - 1) : '0;
			end else begin
				hresp_q  <= 1'b0;
				hready_q <= 1'b1;
			end
		end else if (hresp_q) begin
			// Second ERROR cycle
			hready_q <= 1'b1;
		end else if (wait_cnt == '0) begin
			hready_q <= 1'b1;
		end else begin
			wait_cnt <= wait_cnt - 1'b1;
		end
	end

	always_ff @(posedge clk) begin
		if (accept) begin
			write_q <= req.hwrite;
			word_q  <= req.haddr[2 +: IDX_W];
		end
		// Write lands at the end of an OKAY data phase
		if (hready && active && write_q && !hresp_q)
			mem[word_q] <= hwdata;
	end

	always_comb begin
		resp.hready_resp = hready_q;
		resp.hresp       = hresp_q;
		// Zero when idle or on error
		resp.hrdata      = (active && !hresp_q) ? mem[word_q] : '0;
	end

endmodule

`default_nettype wire

//--- ahbl_arbiter.sv
`timescale 1ns/1ps
`default_nettype none

module ahbl_arbiter #(
	parameter int N_PORTS = 2
) (
	input  logic                                clk,
	input  logic                                rst_n,

	// Master side ports, port 0 has highest priority
	input  ahbl_pkg::ahbl_req_t  [N_PORTS-1:0]  src_req,
	input  ahbl_pkg::hdata_t     [N_PORTS-1:0]  src_hwdata,
	output ahbl_pkg::ahbl_resp_t [N_PORTS-1:0]  src_resp,

	// Slave side port
	output ahbl_pkg::ahbl_req_t                 dst_req,
	output ahbl_pkg::hdata_t                    dst_hwdata,
	output logic                                dst_hready,
	input  ahbl_pkg::ahbl_resp_t                dst_resp
);

	// Per-port address phase buffers
	logic [N_PORTS-1:0]                buf_valid;
	ahbl_pkg::ahbl_req_t [N_PORTS-1:0] buf_req;

	// Buffered request if present, else live
	ahbl_pkg::ahbl_req_t [N_PORTS-1:0] actual_req;

	logic [N_PORTS-1:0] req_a;
	logic [N_PORTS-1:0] prio_gnt;
	logic [N_PORTS-1:0] gnt_a;
	logic [N_PORTS-1:0] gnt_q;
	logic [N_PORTS-1:0] gnt_d;
	logic [N_PORTS-1:0] in_dphase;
	logic [N_PORTS-1:0] src_hready;
	logic [N_PORTS-1:0] aphase_end;
	logic [N_PORTS-1:0] buf_wen;
	logic               stall_q;

	always_comb begin
		for (int i = 0; i < N_PORTS; i++) begin
			actual_req[i] = buf_valid[i] ? buf_req[i] : src_req[i];
			// Upper htrans bit set for NONSEQ and SEQ
			req_a[i] = actual_req[i].htrans[1];
		end
	end

	// Isolate lowest set bit
	assign prio_gnt = req_a & (~req_a + 1'b1);

	// Grant frozen after a wait state so the slave sees a stable address
	assign gnt_a = stall_q ? gnt_q : prio_gnt;

	// One-hot muxes for the slave side
	always_comb begin
		dst_req    = '0;
		dst_hwdata = '0;
		for (int i = 0; i < N_PORTS; i++) begin
			if (gnt_a[i])
				dst_req = actual_req[i];
			// Write data follows the data phase owner
			if (gnt_d[i])
				dst_hwdata = src_hwdata[i];
		end
	end

	// Slave ready only matters once someone owns the data phase
	assign dst_hready = (|gnt_d) ? dst_resp.hready_resp : 1'b1;

	// Master is in data phase with us, possibly not yet with the slave
	assign in_dphase = buf_valid | gnt_d;

	always_comb begin
		for (int i = 0; i < N_PORTS; i++) begin
			src_hready[i] = ~in_dphase[i] | (gnt_d[i] & dst_resp.hready_resp);
			src_resp[i].hready_resp = src_hready[i];
			src_resp[i].hresp       = gnt_d[i] & dst_resp.hresp;
			// Read data goes to every port
			src_resp[i].hrdata      = dst_resp.hrdata;
		end
	end

	// Master thinks its address phase is done
	assign aphase_end = req_a & src_hready;

	// Accepted by us but not by the slave
	assign buf_wen = aphase_end & ~(gnt_a & {N_PORTS{dst_hready}});

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			buf_valid <= '0;
			gnt_d     <= '0;
			gnt_q     <= '0;
			stall_q   <= 1'b0;
		end else begin
			gnt_q   <= gnt_a;
			stall_q <= ~dst_hready;
			if (dst_hready)
				gnt_d <= gnt_a;
			// Granted buffers drain, new misses fill
			buf_valid <= (dst_hready ? (buf_valid & ~gnt_a) : buf_valid) | buf_wen;
		end
	end

	always_ff @(posedge clk) begin
		for (int i = 0; i < N_PORTS; i++) begin
			if (buf_wen[i])
				buf_req[i] <= src_req[i];
		end
	end

endmodule

`default_nettype wire

//--- ahbl_cmd_master.sv
`timescale 1ns/1ps
`default_nettype none

module ahbl_cmd_master (
	input  logic                clk,
	input  logic                rst_n,

	// Command side
	input  logic                cmd_valid,
	input  logic                cmd_write,
	input  ahbl_pkg::haddr_t    cmd_addr,
	input  ahbl_pkg::hdata_t    cmd_wdata,
	output logic                busy,
	output logic                done,
	output ahbl_pkg::hdata_t    rdata,
	output logic                err,

	// AHB-Lite master port
	output ahbl_pkg::ahbl_req_t req,
	output ahbl_pkg::hdata_t    hwdata,
	input  ahbl_pkg::ahbl_resp_t resp
);

	typedef enum logic [1:0] {
		IDLE,
		ADDR,
		DATA
	} state_e;

	state_e state;

	// Latched command
	logic             write_q;
	ahbl_pkg::haddr_t addr_q;
	ahbl_pkg::hdata_t wdata_q;

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			state <= IDLE;
			done  <= 1'b0;
		end else begin
			done <= 1'b0;
			case (state)
				// New commands only accepted when idle
				IDLE: if (cmd_valid) state <= ADDR;
				// Address phase ends on hready high
				ADDR: if (resp.hready_resp) state <= DATA;
				DATA: begin
					if (resp.hready_resp) begin
						state <= IDLE;
						done  <= 1'b1;
					end
				end
				default: state <= IDLE;
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (state == IDLE && cmd_valid) begin
			write_q <= cmd_write;
			addr_q  <= cmd_addr;
			wdata_q <= cmd_wdata;
		end
		// Capture result as the data phase completes
		if (state == DATA && resp.hready_resp) begin
			rdata <= resp.hrdata;
			err   <= resp.hresp;
		end
	end

	// Busy drops together with the done pulse
	assign busy = (state != IDLE);

	always_comb begin
		req.haddr  = addr_q;
		req.hwrite = write_q;
		req.htrans = (state == ADDR) ? ahbl_pkg::NONSEQ : ahbl_pkg::IDLE;
	end

	// Write data held steady over the whole data phase
	assign hwdata = wdata_q;

endmodule

`default_nettype wire

//--- ahbl_pkg.sv
`default_nettype none

package ahbl_pkg;

	// Bus widths
	localparam int W_ADDR = 32;
	localparam int W_DATA = 32;

	// Byte address on the bus
	typedef logic [W_ADDR-1:0] haddr_t;

	// Write or read data word
	typedef logic [W_DATA-1:0] hdata_t;

	// Transfer type encoding
	// Only IDLE and NONSEQ are ever driven here
	typedef enum logic [1:0] {
		IDLE   = 2'b00,
		BUSY   = 2'b01,
		NONSEQ = 2'b10,
		SEQ    = 2'b11
	} htrans_e;

	// Address phase from a master
	// HWDATA is carried separately since it lags by one cycle
	typedef struct packed {
		haddr_t  haddr;
		logic    hwrite;
		htrans_e htrans;
	} ahbl_req_t;

	// Response from a slave back to a master
	typedef struct packed {
		logic   hready_resp;
		logic   hresp;
		hdata_t hrdata;
	} ahbl_resp_t;

endpackage

`default_nettype wire
